/* filelist.f */
verilog/TrapTypes.sv
verilog/MachineTimer.sv
verilog/CsrFile.sv
verilog/InterruptController.sv
verilog/TrapUnit.sv
tb/TrapUnit_properties.sv
tb/TrapUnitTb.sv

/* tb/TrapUnitTb.sv */
// Testbench for the machine-mode trap subsystem
// random and directed stimulus, cycle model of the CSRs and timer,
// per-test report and closing counts

`timescale 1ns/1ns

module TrapUnitTb import TrapTypes::*; ();

    localparam PC_Path MTVEC_INIT = 32'h100;
    localparam int RESET_CYCLES = 16;
    // csrAccess, interruptMix, trapPriority, trapVector, backPressure
    localparam int TEST_CYCLES = 400 + 400 + 200 + 600 + 100;
    localparam int MARGIN_CYCLES = 300;

    typedef struct packed {
        TimerPath    mtime;
        TimerPath    mtimecmp;
        logic        pend, meip, mie, mpie, readyEn, rspValid;
        logic        epcKnown, causeKnown, rspKnown;
        CSR_DataPath mieReg, mtvec, mepc, mcause, rspData;
    } ModelState;

    logic clk = 1'b0, rst;
    logic reqValid, reqReady, rspValid, extInterrupt, pipelineEmpty, recoveryBusy, mret;
    logic fetchStall, trapValid;
    CsrReqType   req;
    CSR_DataPath rspData;
    PC_Path      currentPc, trapTarget, trapRetAddr;

    // stimulus applied on the next rising edge
    logic sValid, sExt, sEmpty, sBusy, sMret;
    CsrReqType sReq;
    PC_Path sPc;

    ModelState cur, nxt;
    logic fireNow;
    PC_Path trapHitTarget;
    CSR_DataPath lastRsp;
    int errors = 0, checks = 0, trapCount = 0, rspCount = 0, testErrors;

    TrapUnit #(.MTVEC_RESET(MTVEC_INIT)) dut0 (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * 10);
        $display("timeout: the tests did not finish in their cycle budget");
        $display("Simulation failed");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // compare this cycle's outputs and work out the next model state
    task automatic evaluate();
        logic rT, rE, stall, trap, ready, fire, rdKnown;
        CauseCodePath cd;
        PC_Path base, tgt;
        CSR_DataPath rd, wd;
        rT = cur.mieReg[7] && cur.pend;
        rE = cur.mieReg[11] && cur.meip;
        cd = rT ? 4'd7 : 4'd11;
        stall = cur.mie && (rT || rE);
        trap = stall && pipelineEmpty && !recoveryBusy;
        base = {cur.mtvec[31:2], 2'b00};
        tgt = (cur.mtvec[1:0] == 2'd1) ? base + 32'(cd) * 4 : base;
        ready = cur.readyEn && !trap;
        fire = reqValid && ready;
        checkValue("fetchStall", fetchStall, stall);
        checkValue("trapValid", trapValid, trap);
        checkValue("reqReady", reqReady, ready);
        checkValue("rspValid", rspValid, cur.rspValid);
        if (stall) checkValue("trapTarget", trapTarget, tgt);
        if (cur.rspValid && cur.rspKnown) checkValue("rspData", rspData, cur.rspData);
        if (cur.epcKnown) checkValue("trapRetAddr", trapRetAddr, cur.mepc);
        if (trapValid && (!pipelineEmpty || recoveryBusy)) begin
            errors++;
            $display("trap fired while the pipeline was busy at %0t", $time);
        end
        if (rspValid) begin
            rspCount++;
            lastRsp = rspData;
        end
        rdKnown = 1'b1;
        case (req.addr)
            CSR_ADDR_MSTATUS:  rd = (32'(cur.mpie) << 7) | (32'(cur.mie) << 3);
            CSR_ADDR_MIE:      rd = cur.mieReg;
            CSR_ADDR_MTVEC:    rd = cur.mtvec;
            CSR_ADDR_MEPC:     {rdKnown, rd} = {cur.epcKnown, cur.mepc};
            CSR_ADDR_MCAUSE:   {rdKnown, rd} = {cur.causeKnown, cur.mcause};
            CSR_ADDR_MIP:      rd = (32'(cur.meip) << 11) | (32'(cur.pend) << 7);
            CSR_ADDR_MTIME:    rd = cur.mtime;
            CSR_ADDR_MTIMECMP: rd = cur.mtimecmp;
            default:           rd = '0;
        endcase
        nxt = cur;
        nxt.mtime = cur.mtime + 1;
        nxt.pend = (cur.mtime >= cur.mtimecmp);
        nxt.meip = extInterrupt;
        nxt.readyEn = 1'b1;
        nxt.rspValid = fire;
        if (fire) begin
            nxt.rspData = rd;
            nxt.rspKnown = rdKnown;
        end
        wd = req.wdata;
        if (fire && req.write) begin
            case (req.addr)
                CSR_ADDR_MSTATUS:  {nxt.mpie, nxt.mie} = {wd[7], wd[3]};
                CSR_ADDR_MIE:      nxt.mieReg = wd & 32'h880;
                CSR_ADDR_MTVEC:    nxt.mtvec = {wd[31:2], 1'b0, wd[1:0] == 2'd1};
                CSR_ADDR_MEPC:     {nxt.epcKnown, nxt.mepc} = {1'b1, wd[31:2], 2'b00};
                CSR_ADDR_MCAUSE:   {nxt.causeKnown, nxt.mcause} = {1'b1, wd};
                CSR_ADDR_MTIME:    nxt.mtime = wd;
                CSR_ADDR_MTIMECMP: nxt.mtimecmp = wd;
                default:           ;
            endcase
        end
        if (trap) begin
            {nxt.mpie, nxt.mie} = {cur.mie, 1'b0};
            {nxt.epcKnown, nxt.mepc} = {1'b1, currentPc};
            {nxt.causeKnown, nxt.mcause} = {1'b1, 32'h8000_0000 | 32'(cd)};
            trapCount++;
            trapHitTarget = trapTarget;
        end
        else if (mret) begin
            {nxt.mie, nxt.mpie} = {cur.mpie, 1'b1};
        end
        fireNow = fire;
    endtask

    task automatic step();
        @(posedge clk);
        cur = nxt;
        reqValid <= sValid;
        req <= sReq;
        extInterrupt <= sExt;
        pipelineEmpty <= sEmpty;
        recoveryBusy <= sBusy;
        currentPc <= sPc;
        mret <= sMret;
        @(negedge clk);
        evaluate();
    endtask

    // hold a request until it transfers, then wait for its response
    task automatic doRequest(input logic w, input CSR_AddrPath a, input CSR_DataPath d);
        int n;
        n = 0;
        sValid = 1'b1;
        sReq = '{write: w, addr: a, wdata: d};
        do begin
            step();
            n++;
        end while (!fireNow && n < 20);
        if (!fireNow) begin
            errors++;
            $display("request to CSR %h was never accepted", a);
        end
        sValid = 1'b0;
        step();
    endtask

    function automatic CSR_AddrPath randomAddr();
        CSR_AddrPath table9 [9] = '{CSR_ADDR_MSTATUS, CSR_ADDR_MIE, CSR_ADDR_MTVEC,
            CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MIP, CSR_ADDR_MTIME,
            CSR_ADDR_MTIMECMP, 12'h7FF};
        return table9[$urandom % 9];
    endfunction

    task automatic reportTest(input string name);
        $display("test %s finished with %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    // one interrupt taken end to end, then mret
    task automatic trapSequence(input CSR_DataPath tvec, input logic both);
        PC_Path pc, base, expTarget;
        CauseCodePath expCode;
        int n, startTraps;
        pc = $urandom & ~32'h3;
        expCode = both ? 4'd7 : 4'd11;
        base = {tvec[31:2], 2'b00};
        expTarget = (tvec[1:0] == 2'd1) ? base + 32'(expCode) * 4 : base;
        {sPc, sEmpty, sBusy, sExt, sMret} = {pc, 1'b1, 1'b0, 1'b1, 1'b0};
        doRequest(1'b1, CSR_ADDR_MSTATUS, 32'h0);
        doRequest(1'b1, CSR_ADDR_MTVEC, tvec);
        doRequest(1'b1, CSR_ADDR_MTIME, 32'h0);
        doRequest(1'b1, CSR_ADDR_MTIMECMP, both ? 32'h0 : 32'hFFFF_FFFF);
        doRequest(1'b1, CSR_ADDR_MIE, 32'h880);
        startTraps = trapCount;
        doRequest(1'b1, CSR_ADDR_MSTATUS, 32'h8);
        n = 0;
        while (trapCount == startTraps && n < 10) begin
            step();
            n++;
        end
        checkValue("trapCount", trapCount - startTraps, 1);
        checkValue("trapTarget", trapHitTarget, expTarget);
        sExt = 1'b0;
        doRequest(1'b0, CSR_ADDR_MCAUSE, 32'h0);
        checkValue("mcause", lastRsp, 32'h8000_0000 | 32'(expCode));
        doRequest(1'b0, CSR_ADDR_MEPC, 32'h0);
        checkValue("mepc", lastRsp, pc);
        doRequest(1'b0, CSR_ADDR_MSTATUS, 32'h0);
        checkValue("mstatus", lastRsp, 32'h80);
        doRequest(1'b1, CSR_ADDR_MIE, 32'h0);
        sMret = 1'b1;
        step();
        sMret = 1'b0;
        step();
        doRequest(1'b0, CSR_ADDR_MSTATUS, 32'h0);
        checkValue("mstatus", lastRsp, 32'h88);
        checkValue("trapRetAddr", trapRetAddr, pc);
        doRequest(1'b1, CSR_ADDR_MSTATUS, 32'h0);
    endtask

    initial begin
        int startRsp;
        void'($urandom(32'h9ce0));
        {rst, reqValid, extInterrupt, pipelineEmpty, recoveryBusy, mret} = 6'b100000;
        req = '0;
        currentPc = '0;
        {sValid, sExt, sEmpty, sBusy, sMret} = '0;
        sReq = '0;
        sPc = '0;
        testErrors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        cur = '0;
        cur.mtimecmp = '1;
        cur.mtvec = MTVEC_INIT;
        @(negedge clk);
        evaluate();

        // random accesses to every CSR, unknown address included
        repeat (400) begin
            sValid = ($urandom % 2 == 0);
            sReq = '{write: $urandom % 2, addr: randomAddr(), wdata: $urandom};
            sPc = $urandom & ~32'h3;
            step();
        end
        reportTest("csrAccess");

        // random interrupt lines, enables and pipeline status
        repeat (400) begin
            sValid = ($urandom % 4 == 0);
            sReq = '{write: 1'b1, addr: ($urandom % 2) ? CSR_ADDR_MIE : CSR_ADDR_MSTATUS,
                wdata: $urandom};
            sExt = $urandom % 2;
            sEmpty = ($urandom % 4 != 0);
            sBusy = ($urandom % 4 == 0);
            sMret = ($urandom % 16 == 0);
            sPc = $urandom & ~32'h3;
            step();
        end
        {sValid, sExt, sMret} = '0;
        reportTest("interruptMix");

        trapSequence(32'h100, 1'b1);
        trapSequence(32'h101, 1'b0);
        reportTest("trapPriority");

        for (int i = 0; i < 6; i++) begin
            trapSequence($urandom, i % 2);
        end
        reportTest("trapVector");

        // request held valid across the trap cycle
        {sEmpty, sBusy} = 2'b10;
        doRequest(1'b1, CSR_ADDR_MSTATUS, 32'h0);
        doRequest(1'b1, CSR_ADDR_MTIMECMP, 32'hFFFF_FFFF);
        doRequest(1'b1, CSR_ADDR_MTIME, 32'h0);
        doRequest(1'b1, CSR_ADDR_MIE, 32'h800);
        sExt = 1'b1;
        sEmpty = 1'b0;
        doRequest(1'b1, CSR_ADDR_MSTATUS, 32'h8);
        step();
        startRsp = rspCount;
        sValid = 1'b1;
        sReq = '{write: 1'b0, addr: CSR_ADDR_MSTATUS, wdata: 32'h0};
        sEmpty = 1'b1;
        step();
        checkValue("trapValid", trapValid, 1'b1);
        checkValue("reqReady", reqReady, 1'b0);
        step();
        if (!fireNow) begin
            errors++;
            $display("request was not taken in the cycle after the trap");
        end
        {sValid, sExt} = 2'b00;
        repeat (3) step();
        checkValue("responses", rspCount - startRsp, 1);
        reportTest("backPressure");

        $display("checks %0d, traps %0d, errors %0d", checks, trapCount, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb/TrapUnit_properties.sv */
// Concurrent assertions for the trap subsystem
// handshake and trap timing rules, bound into TrapUnit

`timescale 1ns/1ns

module TrapUnitProperties (
    input logic clk,
    input logic rst,
    input logic reqValid,
    input logic reqReady,
    input logic rspValid,
    input logic fetchStall,
    input logic trapValid
);

    // a trap is only taken while fetch is held
    assert property (@(posedge clk) disable iff (rst) trapValid |-> fetchStall)
        else $error("trapValid without fetchStall");

    // back-pressure on the CSR port during the trap
    assert property (@(posedge clk) disable iff (rst) trapValid |-> !reqReady)
        else $error("reqReady high in a trap cycle");

    // MIE clears on the trap edge
    assert property (@(posedge clk) disable iff (rst) trapValid |=> !trapValid)
        else $error("trapValid high two cycles in a row");

    assert property (@(posedge clk) disable iff (rst) (reqValid && reqReady) |=> rspValid)
        else $error("no response one cycle after a transfer");

    assert property (@(posedge clk) disable iff (rst)
        rspValid |-> $past(reqValid && reqReady))
        else $error("response without a transfer");

endmodule

bind TrapUnit TrapUnitProperties props0 (
    .clk(clk),
    .rst(rst),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .rspValid(rspValid),
    .fetchStall(fetchStall),
    .trapValid(trapValid)
);

/* verilog/TrapUnit.sv */
// Machine-mode trap subsystem top level
// instances of CsrFile, MachineTimer and InterruptController

`timescale 1ns/1ns

module TrapUnit import TrapTypes::*; #(
    parameter PC_Path MTVEC_RESET = 32'h0
) (
    input  logic        clk,
    input  logic        rst,

    // CSR request port
    input  logic        reqValid,
    input  CsrReqType   req,
    output logic        reqReady,
    output logic        rspValid,
    output CSR_DataPath rspData,

    // interrupt and pipeline status
    input  logic        extInterrupt,
    input  logic        pipelineEmpty,
    input  logic        recoveryBusy,
    input  PC_Path      currentPc,
    input  logic        mret,

    // redirect to fetch
    output logic        fetchStall,
    output logic        trapValid,
    output PC_Path      trapTarget,
    output PC_Path      trapRetAddr
);

    // timer link
    logic         timerWrite;
    logic         timerSelCmp;
    TimerPath     timerWData;
    TimerPath     mtime;
    TimerPath     mtimecmp;
    logic         timerPending;

    // CSR state for the controller
    logic         mstatusMie;
    CSR_DataPath  mieReg;
    logic         meip;
    logic         mtip;
    logic [29:0]  mtvecBase;
    MtvecModeType mtvecMode;
    CauseCodePath code;

    MachineTimer timer0 (
        .clk, .rst, .timerWrite, .timerSelCmp, .timerWData,
        .mtime, .mtimecmp, .timerPending
    );

    CsrFile #(.MTVEC_RESET(MTVEC_RESET)) csr0 (
        .clk, .rst, .reqValid, .req, .reqReady, .rspValid, .rspData,
        .trigger(trapValid), .code, .currentPc, .mret,
        .extInterrupt, .timerPending, .mtime, .mtimecmp,
        .timerWrite, .timerSelCmp, .timerWData,
        .mstatusMie, .mpie(), .mieReg, .meip, .mtip,
        .mtvecBase, .mtvecMode, .mepc(trapRetAddr)
    );

    InterruptController intCtrl0 (
        .mstatusMie, .mieReg, .meip, .mtip, .mtvecBase, .mtvecMode,
        .pipelineEmpty, .recoveryBusy,
        .fetchStall, .trigger(trapValid), .code, .trapTarget
    );

endmodule

/* verilog/InterruptController.sv */
// Interrupt controller
// enable/pending combination with timer priority, fetch stall
// until the pipeline drains, and trap target in direct or vectored mode

`timescale 1ns/1ns

module InterruptController import TrapTypes::*; (
    input  logic         mstatusMie,
    input  CSR_DataPath  mieReg,
    input  logic         meip,
    input  logic         mtip,
    input  logic [29:0]  mtvecBase,
    input  MtvecModeType mtvecMode,

    // pipeline status
    input  logic         pipelineEmpty,
    input  logic         recoveryBusy,

    output logic         fetchStall,
    output logic         trigger,
    output CauseCodePath code,
    output PC_Path       trapTarget
);

    logic reqTimer;
    logic reqExternal;
    logic [29:0] vectorBase;

    always_comb begin
        reqTimer    = mieReg[CSR_MTIE_BIT] && mtip;
        reqExternal = mieReg[CSR_MEIE_BIT] && meip;

        // timer wins when both are pending
        code = reqTimer ? CAUSE_CODE_TIMER : CAUSE_CODE_EXTERNAL;

        // stall only depends on CSR state, so clearing MIE
        // on the trap edge cannot feed back into this cycle
        fetchStall = mstatusMie && (reqTimer || reqExternal);

        // recovery may still be rewriting the PC on an empty pipeline
        trigger = fetchStall && pipelineEmpty && !recoveryBusy;

        // base is in words, so adding code gives base + 4 * code
        vectorBase = mtvecBase + 30'(code);
        if (mtvecMode == MTVEC_MODE_VECTORED) begin
            trapTarget = {vectorBase, 2'b00};
        end
        else begin
            trapTarget = {mtvecBase, 2'b00};
        end
    end

endmodule

/* verilog/CsrFile.sv */
// Machine CSR file
// mstatus (MIE, MPIE), mie, mip, mtvec, mepc and mcause,
// request/response port, trap entry and mret updates,
// forwarding of timer register accesses

`timescale 1ns/1ns

module CsrFile import TrapTypes::*; #(
    parameter PC_Path MTVEC_RESET = 32'h0
) (
    input  logic         clk,
    input  logic         rst,

    // software request port
    input  logic         reqValid,
    input  CsrReqType    req,
    output logic         reqReady,
    output logic         rspValid,
    output CSR_DataPath  rspData,

    // trap control from the interrupt controller
    input  logic         trigger,
    input  CauseCodePath code,
    input  PC_Path       currentPc,
    input  logic         mret,

    // interrupt sources
    input  logic         extInterrupt,
    input  logic         timerPending,

    // timer access
    input  TimerPath     mtime,
    input  TimerPath     mtimecmp,
    output logic         timerWrite,
    output logic         timerSelCmp,
    output TimerPath     timerWData,

    // state seen by the interrupt controller and fetch
    output logic         mstatusMie,
    output logic         mpie,
    output CSR_DataPath  mieReg,
    output logic         meip,
    output logic         mtip,
    output logic [29:0]  mtvecBase,
    output MtvecModeType mtvecMode,
    output PC_Path       mepc
);

    logic         readyEnable;
    logic         reqFire;
    logic         reqWrite;
    CSR_DataPath  readData;
    CSR_DataPath  mcause;
    CSR_DataPath  mstatusValue;
    CSR_DataPath  mipValue;

    // no transfer while the trap is being taken
    always_comb begin
        reqReady = readyEnable && !trigger;
        reqFire  = reqValid && reqReady;
        reqWrite = reqFire && req.write;
        mtip     = timerPending;
    end

    always_comb begin
        mstatusValue = '0;
        mstatusValue[CSR_MSTATUS_MIE_BIT]  = mstatusMie;
        mstatusValue[CSR_MSTATUS_MPIE_BIT] = mpie;

        mipValue = '0;
        mipValue[CSR_MTIP_BIT] = mtip;
        mipValue[CSR_MEIP_BIT] = meip;

        // unknown addresses read as zero
        case (req.addr)
            CSR_ADDR_MSTATUS:  readData = mstatusValue;
            CSR_ADDR_MIE:      readData = mieReg;
            CSR_ADDR_MTVEC:    readData = {mtvecBase, mtvecMode};
            CSR_ADDR_MEPC:     readData = mepc;
            CSR_ADDR_MCAUSE:   readData = mcause;
            CSR_ADDR_MIP:      readData = mipValue;
            CSR_ADDR_MTIME:    readData = mtime;
            CSR_ADDR_MTIMECMP: readData = mtimecmp;
            default:           readData = '0;
        endcase
    end

    // timer writes go straight through to MachineTimer
    always_comb begin
        timerWrite  = reqWrite &&
            (req.addr == CSR_ADDR_MTIME || req.addr == CSR_ADDR_MTIMECMP);
        timerSelCmp = (req.addr == CSR_ADDR_MTIMECMP);
        timerWData  = req.wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readyEnable <= 1'b0;
            rspValid    <= 1'b0;
            mstatusMie  <= 1'b0;
            mpie        <= 1'b0;
            mieReg      <= '0;
            meip        <= 1'b0;
            mtvecBase   <= MTVEC_RESET[31:2];
            mtvecMode   <= (MTVEC_RESET[1:0] == 2'd1) ? MTVEC_MODE_VECTORED : MTVEC_MODE_DIRECT;
        end
        else begin
            readyEnable <= 1'b1;
            rspValid    <= reqFire;
            meip        <= extInterrupt;

            if (reqWrite && req.addr == CSR_ADDR_MSTATUS) begin
                mstatusMie <= req.wdata[CSR_MSTATUS_MIE_BIT];
                mpie       <= req.wdata[CSR_MSTATUS_MPIE_BIT];
            end
            if (reqWrite && req.addr == CSR_ADDR_MIE) begin
                mieReg <= '0;
                mieReg[CSR_MTIE_BIT] <= req.wdata[CSR_MTIE_BIT];
                mieReg[CSR_MEIE_BIT] <= req.wdata[CSR_MEIE_BIT];
            end
            if (reqWrite && req.addr == CSR_ADDR_MTVEC) begin
                mtvecBase <= req.wdata[31:2];
                // reserved modes fall back to direct
                mtvecMode <= (req.wdata[1:0] == 2'd1) ? MTVEC_MODE_VECTORED : MTVEC_MODE_DIRECT;
            end

            // trap entry beats mret, both beat a software write
            if (trigger) begin
                mpie       <= mstatusMie;
                mstatusMie <= 1'b0;
            end
            else if (mret) begin
                mstatusMie <= mpie;
                mpie       <= 1'b1;
            end
        end
    end

    // old value goes back on writes as well
    always_ff @(posedge clk) begin
        if (reqFire) begin
            rspData <= readData;
        end
    end

    always_ff @(posedge clk) begin
        if (trigger) begin
            mepc   <= currentPc;
            mcause <= '0;
            mcause[CSR_MCAUSE_INTERRUPT_BIT] <= 1'b1;
            mcause[3:0] <= code;
        end
        else begin
            if (reqWrite && req.addr == CSR_ADDR_MEPC) begin
                mepc <= {req.wdata[31:2], 2'b00};
            end
            if (reqWrite && req.addr == CSR_ADDR_MCAUSE) begin
                mcause <= req.wdata;
            end
        end
    end

endmodule

/* verilog/MachineTimer.sv */
// Machine timer
// free-running mtime counter, writable mtimecmp compare register
// and the registered timer-pending flag

`timescale 1ns/1ns

module MachineTimer import TrapTypes::*; (
    input  logic     clk,
    input  logic     rst,

    // write port from the CSR file
    input  logic     timerWrite,
    input  logic     timerSelCmp,
    input  TimerPath timerWData,

    output TimerPath mtime,
    output TimerPath mtimecmp,
    output logic     timerPending
);

    logic writeTime;
    logic writeCmp;
    logic timeReached;

    always_comb begin
        writeTime = timerWrite && !timerSelCmp;
        writeCmp  = timerWrite && timerSelCmp;

        // unsigned compare of the current register values
        timeReached = (mtime >= mtimecmp);
    end

    // software write wins over the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end
        else if (writeTime) begin
            mtime <= timerWData;
        end
        else begin
            mtime <= mtime + TimerPath'(1);
        end
    end

    // all ones keeps the timer quiet until software arms it
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end
        else if (writeCmp) begin
            mtimecmp <= timerWData;
        end
    end

    // pending is one cycle behind the compare
    always_ff @(posedge clk) begin
        if (rst) begin
            timerPending <= 1'b0;
        end
        else begin
            timerPending <= timeReached;
        end
    end

endmodule

/* verilog/TrapTypes.sv */
// Shared types for the machine-mode trap subsystem
// path typedefs, CSR numbers, interrupt cause codes,
// CSR bit positions, mtvec mode encoding and the CSR request struct

package TrapTypes;

    // data path widths
    typedef logic [31:0] PC_Path;
    typedef logic [31:0] CSR_DataPath;
    typedef logic [11:0] CSR_AddrPath;
    typedef logic [31:0] TimerPath;
    typedef logic [3:0]  CauseCodePath;

    // mtvec.mode field, values above 1 are reserved
    typedef enum logic [1:0] {
        MTVEC_MODE_DIRECT   = 2'd0,
        MTVEC_MODE_VECTORED = 2'd1
    } MtvecModeType;

    // one CSR access from software
    typedef struct packed {
        logic        write;
        CSR_AddrPath addr;
        CSR_DataPath wdata;
    } CsrReqType;

    // standard machine CSR numbers
    localparam CSR_AddrPath CSR_ADDR_MSTATUS  = 12'h300;
    localparam CSR_AddrPath CSR_ADDR_MIE      = 12'h304;
    localparam CSR_AddrPath CSR_ADDR_MTVEC    = 12'h305;
    localparam CSR_AddrPath CSR_ADDR_MEPC     = 12'h341;
    localparam CSR_AddrPath CSR_ADDR_MCAUSE   = 12'h342;
    localparam CSR_AddrPath CSR_ADDR_MIP      = 12'h344;

    // timer registers live in the custom read/write CSR range
    localparam CSR_AddrPath CSR_ADDR_MTIME    = 12'h7C0;
    localparam CSR_AddrPath CSR_ADDR_MTIMECMP = 12'h7C1;

    // interrupt cause codes in mcause
    localparam CauseCodePath CAUSE_CODE_TIMER    = 4'd7;
    localparam CauseCodePath CAUSE_CODE_EXTERNAL = 4'd11;

    // mstatus bit positions
    localparam int CSR_MSTATUS_MIE_BIT  = 3;
    localparam int CSR_MSTATUS_MPIE_BIT = 7;

    // mie and mip bit positions
    localparam int CSR_MTIE_BIT = 7;
    localparam int CSR_MTIP_BIT = 7;
    localparam int CSR_MEIE_BIT = 11;
    localparam int CSR_MEIP_BIT = 11;

    // mcause flags an interrupt with its top bit
    localparam int CSR_MCAUSE_INTERRUPT_BIT = 31;

endpackage
